// File: tb.f
common/conv_pkg.sv
hw/conv_tiling/conv_tiling.sv
hw/conv_tiling/conv_input_window.sv
hw/conv_row_engine.sv
hw/conv_tile_top.sv
testbench/conv_tile_asserts.sv
testbench/conv_tile_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module conv_tile_tb -o conv_tile_sim

# assertion failures must not stop the run before the closing report
./obj_dir/conv_tile_sim +verilator+error+limit+100000 > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
   echo "run passed"
else
   echo "run failed"
   exit 1
fi

// File: testbench/conv_tile_tb.sv
module conv_tile_tb;
   import conv_pkg::*;

   localparam int pixels_in_row = 32;
   localparam int buffers_num   = 3;
   localparam int row_num_mode0 = 64;
   localparam int row_num_mode1 = 128;
   localparam int num_layers    = 7;

   logic      clk = 1'b0;
   logic      reset;
   logic      en;
   tile_cfg_t cfg;
   tile_pos_t pos;
   win_t      win;
   logic      tile_done;
   logic      layer_done;

   tile_cfg_t layers[num_layers];
   int        seed = 71;
   int        errors = 0;
   int        budget = 0;
   int        tiles_seen = 0;
   int        tiles_expected = 0;
   bit        layer_seen = 1'b0;
   bit        check_restart = 1'b0;
   // reference loop indices
   int        m_if = 1;
   int        m_f = 1;
   int        m_x = 1;
   int        m_y = 1;
   int        m_rb = 0;

   conv_tile_top #(
      .pixels_in_row (pixels_in_row),
      .buffers_num   (buffers_num),
      .row_num_mode0 (row_num_mode0),
      .row_num_mode1 (row_num_mode1)
   ) dut (
      .clk        (clk),
      .reset      (reset),
      .en         (en),
      .cfg        (cfg),
      .pos        (pos),
      .win        (win),
      .tile_done  (tile_done),
      .layer_done (layer_done)
   );

   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // reference loop model
   ////////////////////////////////////////////////////////////////////////////

   function automatic int rows_of(input tile_cfg_t c);
      return c.mode ? row_num_mode1 : row_num_mode0;
   endfunction

   function automatic int tile_count(input int n, input int step);
      return (n + step - 1) / step;
   endfunction

   function automatic int size_at(input int start, input int step, input int limit);
      return (start + step - 1 > limit) ? limit - start + 1 : step;
   endfunction

   // input size chosen so the kernel just covers the padded image
   function automatic tile_cfg_t make_cfg(input int mode, input int of, input int ox,
                                          input int oy, input int nif, input int k,
                                          input int s, input int p);
      tile_cfg_t c;
      c.mode = mode[0];
      c.of   = 16'(of);
      c.ox   = 16'(ox);
      c.oy   = 16'(oy);
      c.nif  = 16'(nif);
      c.k    = 4'(k);
      c.s    = 4'(s);
      c.p    = 4'(p);
      c.ix   = 16'((ox - 1) * s + k - 2 * p);
      c.iy   = 16'((oy - 1) * s + k - 2 * p);
      return c;
   endfunction

   function automatic bit last_tile();
      return m_if == int'(cfg.nif) && m_f + rows_of(cfg) > int'(cfg.of)
         && m_x + pixels_in_row > int'(cfg.ox) && m_y + buffers_num > int'(cfg.oy);
   endfunction

   task automatic compare_value(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic compare_pos();
      compare_value("pos.if_idx", int'(pos.if_idx), m_if);
      compare_value("pos.of_start", int'(pos.of_start), m_f);
      compare_value("pos.ox_start", int'(pos.ox_start), m_x);
      compare_value("pos.oy_start", int'(pos.oy_start), m_y);
      compare_value("pos.row_base", int'(pos.row_base), m_rb);
      compare_value("pos.pof", int'(pos.pof), size_at(m_f, rows_of(cfg), int'(cfg.of)));
      compare_value("pos.pox", int'(pos.pox), size_at(m_x, pixels_in_row, int'(cfg.ox)));
      compare_value("pos.poy", int'(pos.poy), size_at(m_y, buffers_num, int'(cfg.oy)));
   endtask

   // if innermost, then of, ox and oy
   task automatic step_model();
      m_if++;
      if (m_if > int'(cfg.nif)) begin
         m_if = 1;
         m_f += rows_of(cfg);
         if (m_f > int'(cfg.of)) begin
            m_f = 1;
            m_x += pixels_in_row;
            if (m_x > int'(cfg.ox)) begin
               m_x = 1;
               m_y += buffers_num;
               m_rb++;
               if (m_y > int'(cfg.oy)) begin
                  m_y  = 1;
                  m_rb = 0;
               end
            end
         end
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         if (check_restart) begin
            compare_value("pos.of_start", int'(pos.of_start), 1);
            compare_value("pos.ox_start", int'(pos.ox_start), 1);
            compare_value("pos.oy_start", int'(pos.oy_start), 1);
            compare_value("pos.if_idx", int'(pos.if_idx), 1);
            compare_value("pos.row_base", int'(pos.row_base), 0);
            check_restart = 1'b0;
         end
         if (tile_done) begin
            compare_pos();
            compare_value("layer_done", int'(layer_done), int'(last_tile()));
            tiles_seen++;
            if (layer_done) begin
               compare_value("tile_done count", tiles_seen, tiles_expected);
               tiles_seen    = 0;
               check_restart = 1'b1;
               layer_seen    = 1'b1;
            end
            step_model();
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_layer(input tile_cfg_t c);
      @(posedge clk);
      cfg <= c;
      en  <= 1'b1;
      tiles_expected = int'(c.nif) * tile_count(int'(c.of), rows_of(c))
         * tile_count(int'(c.ox), pixels_in_row) * tile_count(int'(c.oy), buffers_num);
      layer_seen = 1'b0;
      @(posedge clk);
      while (!layer_seen) begin
         // short random stalls of the array
         if (en) begin
            en <= ($unsigned($random(seed)) % 16) != 0;
         end else begin
            en <= ($unsigned($random(seed)) % 3) == 0;
         end
         @(posedge clk);
      end
      en <= 1'b0;
   endtask

   initial begin
      reset = 1'b1;
      en    = 1'b0;
      layers[0] = make_cfg(0, 40, 45, 7, 2, 3, 1, 1);
      layers[1] = make_cfg(1, 200, 32, 6, 1, 3, 2, 1);
      layers[2] = make_cfg(0, 130, 70, 4, 3, 1, 1, 0);
      layers[3] = make_cfg(1, 100, 20, 3, 2, 5, 2, 2);
      for (int i = 4; i < num_layers; i++) begin
         layers[i] = make_cfg($unsigned($random(seed)) % 2, 1 + $unsigned($random(seed)) % 260,
                              1 + $unsigned($random(seed)) % 80, 1 + $unsigned($random(seed)) % 11,
                              1 + $unsigned($random(seed)) % 3, 3,
                              1 + $unsigned($random(seed)) % 2, 1);
      end
      for (int i = 0; i < num_layers; i++) begin
         budget += int'(layers[i].nif) * tile_count(int'(layers[i].of), rows_of(layers[i]))
            * int'(layers[i].ox) * int'(layers[i].oy);
      end
      budget = 2 * budget + 1000;
      cfg = layers[0];

      repeat (10) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < num_layers; i++) begin
         run_layer(layers[i]);
      end
      repeat (5) @(posedge clk);

      $display("errors: model %0d, assertions %0d", errors, dut.u_asserts.fail_count);
      if (errors == 0 && dut.u_asserts.fail_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (budget > 0);
      #(budget * 10);
      $display("timeout: layers not finished within %0d cycles", budget);
      $display("errors: model %0d, assertions %0d", errors, dut.u_asserts.fail_count);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: testbench/conv_tile_asserts.sv
module conv_tile_asserts #(
   parameter int pixels_in_row = 32,
   parameter int buffers_num   = 3,
   parameter int row_num_mode0 = 64,
   parameter int row_num_mode1 = 128
) (
   input logic                clk,
   input logic                reset,
   input logic                en,
   input conv_pkg::tile_cfg_t cfg,
   input conv_pkg::tile_pos_t pos,
   input conv_pkg::win_t      win,
   input logic                tile_done,
   input logic                layer_done
);

   int fail_count = 0;
   // enabled cycles since the last tile_done
   int en_cycles;
   int exp_pof;
   int exp_pox;
   int exp_poy;
   int raw_w;
   int raw_h;

   function automatic int edge_size(input int start, input int step, input int limit);
      if (start + step - 1 > limit) begin
         return limit - start + 1;
      end
      return step;
   endfunction

   task automatic record_failure(input string what);
      $error("%s", what);
      fail_count = fail_count + 1;
   endtask

   always_comb begin
      exp_pof = edge_size(int'(pos.of_start), cfg.mode ? row_num_mode1 : row_num_mode0,
                          int'(cfg.of));
      exp_pox = edge_size(int'(pos.ox_start), pixels_in_row, int'(cfg.ox));
      exp_poy = edge_size(int'(pos.oy_start), buffers_num, int'(cfg.oy));
      // kernel footprint of the tile before clipping
      raw_w   = (int'(pos.pox) - 1) * int'(cfg.s) + int'(cfg.k);
      raw_h   = (int'(pos.poy) - 1) * int'(cfg.s) + int'(cfg.k);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         en_cycles <= 0;
      end else if (en) begin
         en_cycles <= tile_done ? 0 : en_cycles + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // properties
   ////////////////////////////////////////////////////////////////////////////

   reset_state: assert property (@(posedge clk)
      reset |=> pos.of_start == 16'd1 && pos.ox_start == 16'd1 && pos.oy_start == 16'd1
         && pos.if_idx == 16'd1 && pos.row_base == 16'd0 && !tile_done && !layer_done)
      else record_failure("loop counters not on the first tile after reset");

   tile_sizes: assert property (@(posedge clk) disable iff (reset)
      int'(pos.pof) == exp_pof && int'(pos.pox) == exp_pox && int'(pos.poy) == exp_poy)
      else record_failure("tile size does not follow the edge clipping");

   idle_quiet: assert property (@(posedge clk) disable iff (reset) !en |-> !tile_done)
      else record_failure("tile_done pulsed while en was low");

   tile_interval: assert property (@(posedge clk) disable iff (reset)
      tile_done |-> en_cycles + 1 == int'(pos.pox) * int'(pos.poy))
      else record_failure("tile took a different number of enabled cycles than pox*poy");

   // every loop wraps together at the end of a layer
   layer_end: assert property (@(posedge clk) disable iff (reset)
      layer_done |=> pos.of_start == 16'd1 && pos.ox_start == 16'd1
         && pos.oy_start == 16'd1 && pos.if_idx == 16'd1 && pos.row_base == 16'd0)
      else record_failure("loop counters not back on the first tile after layer_done");

   window_x: assert property (@(posedge clk) disable iff (reset)
      int'(win.iw) + int'(win.pad_left) + int'(win.pad_right) == raw_w
         && int'(win.iw) <= int'(cfg.ix)
         && win.ix_start == 17'((int'(pos.ox_start) - 1) * int'(cfg.s) - int'(cfg.p) + 1))
      else record_failure("input window in x breaks the width or padding rule");

   window_y: assert property (@(posedge clk) disable iff (reset)
      int'(win.ih) + int'(win.pad_top) + int'(win.pad_bottom) == raw_h
         && int'(win.ih) <= int'(cfg.iy)
         && win.iy_start == 17'((int'(pos.oy_start) - 1) * int'(cfg.s) - int'(cfg.p) + 1))
      else record_failure("input window in y breaks the height or padding rule");

endmodule

bind conv_tile_top conv_tile_asserts #(
   .pixels_in_row (pixels_in_row),
   .buffers_num   (buffers_num),
   .row_num_mode0 (row_num_mode0),
   .row_num_mode1 (row_num_mode1)
) u_asserts (
   .clk        (clk),
   .reset      (reset),
   .en         (en),
   .cfg        (cfg),
   .pos        (pos),
   .win        (win),
   .tile_done  (tile_done),
   .layer_done (layer_done)
);

// File: hw/conv_tile_top.sv
module conv_tile_top #(
   parameter int pixels_in_row = 32,
   parameter int buffers_num   = 3,
   parameter int row_num_mode0 = 64,
   parameter int row_num_mode1 = 128
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                en,
   input  conv_pkg::tile_cfg_t cfg,
   output conv_pkg::tile_pos_t pos,
   output conv_pkg::win_t      win,
   output logic                tile_done,
   output logic                layer_done
);

   ////////////////////////////////////////////////////////////////////////////
   // tile loops
   ////////////////////////////////////////////////////////////////////////////

   conv_tiling #(
      .pixels_in_row (pixels_in_row),
      .buffers_num   (buffers_num),
      .row_num_mode0 (row_num_mode0),
      .row_num_mode1 (row_num_mode1)
   ) u_tiling (
      .clk        (clk),
      .reset      (reset),
      .cfg        (cfg),
      .tile_done  (tile_done),
      .pos        (pos),
      .layer_done (layer_done)
   );

   // input rectangle of the current tile, no latency
   conv_input_window u_window (
      .cfg (cfg),
      .pos (pos),
      .win (win)
   );

   ////////////////////////////////////////////////////////////////////////////
   // compute array schedule
   ////////////////////////////////////////////////////////////////////////////

   conv_row_engine u_row_engine (
      .clk       (clk),
      .reset     (reset),
      .en        (en),
      .pox       (pos.pox),
      .poy       (pos.poy),
      .tile_done (tile_done)
   );

endmodule

// File: hw/conv_row_engine.sv
module conv_row_engine (
   input  logic        clk,
   input  logic        reset,
   input  logic        en,
   input  logic [15:0] pox,
   input  logic [15:0] poy,
   output logic        tile_done
);

   ////////////////////////////////////////////////////////////////////////////
   // sweep state
   ////////////////////////////////////////////////////////////////////////////

   // pixel within the current buffered row
   logic [15:0] px_cnt;
   // buffered row within the tile
   logic [15:0] row_cnt;

   logic        last_px;
   logic        last_row;

   // >= keeps the sweep bounded even if a size is zero
   assign last_px  = (({1'b0, px_cnt} + 17'd1) >= {1'b0, pox});
   assign last_row = (({1'b0, row_cnt} + 17'd1) >= {1'b0, poy});

   // pulse in the cycle that consumes the last pixel
   assign tile_done = en && last_px && last_row;

   ////////////////////////////////////////////////////////////////////////////
   // one output pixel per enabled cycle
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         px_cnt  <= 16'd0;
         row_cnt <= 16'd0;
      end else if (en) begin
         if (last_px) begin
            px_cnt <= 16'd0;
            if (last_row) begin
               // next tile sizes are already on pox and poy
               row_cnt <= 16'd0;
            end else begin
               row_cnt <= row_cnt + 16'd1;
            end
         end else begin
            px_cnt <= px_cnt + 16'd1;
         end
      end
      // en low holds the position
   end

endmodule

// File: hw/conv_tiling/conv_input_window.sv
module conv_input_window (
   input  conv_pkg::tile_cfg_t cfg,
   input  conv_pkg::tile_pos_t pos,
   output conv_pkg::win_t      win
);
   import conv_pkg::*;

   win_axis_t x_axis;
   win_axis_t y_axis;

   ////////////////////////////////////////////////////////////////////////////
   // one axis of the output tile mapped back to input coordinates
   ////////////////////////////////////////////////////////////////////////////

   function automatic win_axis_t map_axis(input logic [15:0] o_start,
                                          input logic [15:0] po,
                                          input logic [3:0]  s,
                                          input logic [3:0]  k,
                                          input logic [3:0]  p,
                                          input logic [15:0] limit);
      int        first;
      int        raw;
      int        last;
      int        lo;
      int        hi;
      win_axis_t a;

      // first input column touched by the tile, may sit in the padding
      first = (int'(o_start) - 1) * int'(s) - int'(p) + 1;
      // span of the kernel across the whole tile
      raw   = (int'(po) - 1) * int'(s) + int'(k);
      last  = first + raw - 1;

      // columns left of the image
      if (first < 1) begin
         lo = 1 - first;
      end else begin
         lo = 0;
      end

      // columns right of the image
      if (last > int'(limit)) begin
         hi = last - int'(limit);
      end else begin
         hi = 0;
      end

      a.start  = first[16:0];
      a.len    = 16'(raw - lo - hi);
      a.pad_lo = 4'(lo);
      a.pad_hi = 4'(hi);
      return a;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // both axes
   ////////////////////////////////////////////////////////////////////////////

   // the loader fetches only iw x ih real pixels, pads are zero filled
   always_comb begin
      x_axis = map_axis(pos.ox_start, pos.pox, cfg.s, cfg.k, cfg.p, cfg.ix);
      y_axis = map_axis(pos.oy_start, pos.poy, cfg.s, cfg.k, cfg.p, cfg.iy);

      win.ix_start   = x_axis.start;
      win.iw         = x_axis.len;
      win.pad_left   = x_axis.pad_lo;
      win.pad_right  = x_axis.pad_hi;

      win.iy_start   = y_axis.start;
      win.ih         = y_axis.len;
      win.pad_top    = y_axis.pad_lo;
      win.pad_bottom = y_axis.pad_hi;
   end

endmodule

// File: hw/conv_tiling/conv_tiling.sv
module conv_tiling #(
   parameter int pixels_in_row = 32,
   parameter int buffers_num   = 3,
   parameter int row_num_mode0 = 64,
   parameter int row_num_mode1 = 128
) (
   input  logic                clk,
   input  logic                reset,
   input  conv_pkg::tile_cfg_t cfg,
   input  logic                tile_done,
   output conv_pkg::tile_pos_t pos,
   output logic                layer_done
);
   import conv_pkg::*;

   // loop steps
   logic [15:0] row_num;
   logic [15:0] x_step;
   logic [15:0] y_step;

   // loop counters, innermost first
   logic [15:0] if_cnt;
   logic [15:0] f_cnt;
   logic [15:0] x_cnt;
   logic [15:0] y_cnt;
   logic [15:0] row_base;

   // wrap of each loop, which is also the step of the next outer one
   logic        if_done;
   logic        f_wrap;
   logic        x_wrap;
   logic        y_wrap;

   // 8 bit mode keeps fewer output features per tile
   assign row_num = cfg.mode ? 16'(row_num_mode1) : 16'(row_num_mode0);
   assign x_step  = 16'(pixels_in_row);
   assign y_step  = 16'(buffers_num);

   ////////////////////////////////////////////////////////////////////////////
   // wrap chain
   ////////////////////////////////////////////////////////////////////////////

   // 17 bit sums so a start near the top of the range cannot roll over
   assign if_done = tile_done && (({1'b0, if_cnt} + 17'd1) > {1'b0, cfg.nif});
   assign f_wrap  = if_done && (({1'b0, f_cnt} + {1'b0, row_num}) > {1'b0, cfg.of});
   assign x_wrap  = f_wrap && (({1'b0, x_cnt} + {1'b0, x_step}) > {1'b0, cfg.ox});
   assign y_wrap  = x_wrap && (({1'b0, y_cnt} + {1'b0, y_step}) > {1'b0, cfg.oy});

   // last tile of the last row of tiles
   assign layer_done = y_wrap;

   ////////////////////////////////////////////////////////////////////////////
   // counters
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         if_cnt   <= 16'd1;
         f_cnt    <= 16'd1;
         x_cnt    <= 16'd1;
         y_cnt    <= 16'd1;
         row_base <= 16'd0;
      end else begin
         // input features, one per finished tile pass
         if (tile_done) begin
            if (if_done) begin
               if_cnt <= 16'd1;
            end else begin
               if_cnt <= if_cnt + 16'd1;
            end
         end

         // output feature tile
         if (if_done) begin
            if (f_wrap) begin
               f_cnt <= 16'd1;
            end else begin
               f_cnt <= f_cnt + row_num;
            end
         end

         // x tile
         if (f_wrap) begin
            if (x_wrap) begin
               x_cnt <= 16'd1;
            end else begin
               x_cnt <= x_cnt + x_step;
            end
         end

         // y tile, row_base follows it in units of buffers
         if (x_wrap) begin
            if (y_wrap) begin
               y_cnt    <= 16'd1;
               row_base <= 16'd0;
            end else begin
               y_cnt    <= y_cnt + y_step;
               row_base <= row_base + 16'd1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // tile position and clipped sizes
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      pos.of_start = f_cnt;
      pos.ox_start = x_cnt;
      pos.oy_start = y_cnt;
      pos.if_idx   = if_cnt;
      pos.row_base = row_base;
      // partial tiles at the right, bottom and feature edge
      pos.pof      = clip_tile(f_cnt, row_num, cfg.of);
      pos.pox      = clip_tile(x_cnt, x_step, cfg.ox);
      pos.poy      = clip_tile(y_cnt, y_step, cfg.oy);
   end

endmodule

// File: common/conv_pkg.sv
package conv_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // layer configuration, stable for a whole run
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic        mode;
      logic [15:0] of;
      logic [15:0] ox;
      logic [15:0] oy;
      logic [15:0] ix;
      logic [15:0] iy;
      logic [15:0] nif;
      logic [3:0]  k;
      logic [3:0]  s;
      logic [3:0]  p;
   } tile_cfg_t;

   // current tile, all 1-based except row_base
   typedef struct packed {
      logic [15:0] of_start;
      logic [15:0] ox_start;
      logic [15:0] oy_start;
      logic [15:0] pof;
      logic [15:0] pox;
      logic [15:0] poy;
      logic [15:0] if_idx;
      logic [15:0] row_base;
   } tile_pos_t;

   ////////////////////////////////////////////////////////////////////////////
   // input window
   ////////////////////////////////////////////////////////////////////////////

   // one axis of the window, before it is spread into win_t
   typedef struct packed {
      logic signed [16:0] start;
      logic [15:0]        len;
      logic [3:0]         pad_lo;
      logic [3:0]         pad_hi;
   } win_axis_t;

   typedef struct packed {
      logic signed [16:0] ix_start;
      logic signed [16:0] iy_start;
      logic [15:0]        iw;
      logic [15:0]        ih;
      logic [3:0]         pad_left;
      logic [3:0]         pad_top;
      logic [3:0]         pad_right;
      logic [3:0]         pad_bottom;
   } win_t;

   // tile size along one loop, cut short on the last tile
   function automatic logic [15:0] clip_tile(input logic [15:0] start,
                                             input logic [15:0] step,
                                             input logic [15:0] limit);
      logic [16:0] last;
      last = {1'b0, start} + {1'b0, step} - 17'd1;
      if (last > {1'b0, limit}) begin
         return limit - start + 16'd1;
      end
      return step;
   endfunction

endpackage
